//--- common/hamming.svh
`ifndef HAMMING_SVH
`define HAMMING_SVH

// Width helpers for the classic Hamming layout
// Parity bits sit at the power-of-two positions of a 1-based block

// Smallest parity count p with 2^p - p - 1 >= data width
// Steps follow the full-length codes (1, 4, 11, 26, 57, 120, 247 data bits)
// Anything above 247 data bits falls on 8 parity bits and overflows the syndrome
`define GET_HAMMING_PARITY_WIDTH(data_width) \
  (((data_width) <=   1) ? 2 : \
   ((data_width) <=   4) ? 3 : \
   ((data_width) <=  11) ? 4 : \
   ((data_width) <=  26) ? 5 : \
   ((data_width) <=  57) ? 6 : \
   ((data_width) <= 120) ? 7 : 8)

// Full data width of a code with the given parity count
// Used to pad shortened codes up to their natural length
`define GET_HAMMING_DATA_WIDTH(parity_width) \
  ((2 ** (parity_width)) - (parity_width) - 1)

`endif

//--- common/hamming_pkg.sv
package hamming_pkg;

  // Syndrome register width, 8 bits covers blocks up to 255 positions
  // so data words up to 247 bits
  localparam int SYNDROME_MAX_WIDTH = 8;

  // 1-based position of a single flipped bit, zero for a clean block
  typedef logic [SYNDROME_MAX_WIDTH-1:0] syndrome_t;

  // Decoder status, valid alongside the decoded data
  typedef struct packed {
    // Syndrome is nonzero
    logic      error;
    // Syndrome addressed a bit inside the block, that bit was flipped
    logic      corrected;
    // Syndrome points past a shortened block, multiple errors
    logic      invalid;
    syndrome_t syndrome;
  } decode_status_t;

  // True for the parity positions 1, 2, 4, 8 ...
  function automatic logic is_parity_position(input int unsigned position);
    return (position != 0) && ((position & (position - 1)) == 0);
  endfunction

  // True when the parity bit of the given index covers this 1-based position
  // i.e. when that bit of the position number is set
  function automatic logic covers_position(
    input int unsigned position,
    input int unsigned syndrome_bit
  );
    return ((position >> syndrome_bit) & 1) != 0;
  endfunction

endpackage

//--- hamming/hamming_block_packer.sv
`timescale 1ns/100ps

`include "hamming.svh"

module hamming_block_packer import hamming_pkg::*; #(
  parameter  DATA_WIDTH   = 8,
  localparam PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH
) (
  input  logic   [DATA_WIDTH-1:0] data,
  input  logic [PARITY_WIDTH-1:0] code,
  output logic  [BLOCK_WIDTH-1:0] block
);

  // Walk the block positions from 1 upward
  // Parity bits land on powers of two, data fills the gaps in order
  always_comb begin
    int data_index;
    int parity_index;
    block        = '0;
    data_index   = 0;
    parity_index = 0;
    for (int position = 1; position <= BLOCK_WIDTH; position++) begin
      if (is_parity_position(position)) begin
        // Next parity bit, LSB of code goes to position 1
        block[position-1] = code[parity_index];
        parity_index++;
      end else begin
        // Next data bit, LSB of data goes to position 3
        block[position-1] = data[data_index];
        data_index++;
      end
    end
  end

endmodule

//--- hamming/hamming_block_unpacker.sv
`timescale 1ns/100ps

`include "hamming.svh"

module hamming_block_unpacker import hamming_pkg::*; #(
  parameter  DATA_WIDTH   = 8,
  localparam PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH
) (
  input  logic  [BLOCK_WIDTH-1:0] block,
  output logic   [DATA_WIDTH-1:0] data,
  output logic [PARITY_WIDTH-1:0] code
);

  // Same walk as the packer, run the other way
  // Each position is routed back to its data or parity slot
  always_comb begin
    int data_index;
    int parity_index;
    data         = '0;
    code         = '0;
    data_index   = 0;
    parity_index = 0;
    for (int position = 1; position <= BLOCK_WIDTH; position++) begin
      if (is_parity_position(position)) begin
        // Power of two, belongs to the code
        code[parity_index] = block[position-1];
        parity_index++;
      end else begin
        // Everything else is payload, in ascending order
        data[data_index] = block[position-1];
        data_index++;
      end
    end
  end

endmodule

//--- hamming/hamming_encoder.sv
`timescale 1ns/100ps

`include "hamming.svh"

module hamming_encoder import hamming_pkg::*; #(
  parameter  DATA_WIDTH   = 8,
  localparam PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH
) (
  input  logic   [DATA_WIDTH-1:0] data,
  output logic [PARITY_WIDTH-1:0] code,
  output logic  [BLOCK_WIDTH-1:0] block
);

  // Shortened codes are padded with zeros up to the full length
  // Zero data bits add nothing to the parity, so the code is unchanged
  localparam PADDED_DATA_WIDTH  = `GET_HAMMING_DATA_WIDTH(PARITY_WIDTH);
  localparam PADDED_BLOCK_WIDTH = PADDED_DATA_WIDTH + PARITY_WIDTH;

  logic  [PADDED_DATA_WIDTH-1:0] data_padded;
  logic [PADDED_BLOCK_WIDTH-1:0] block_padded;
  logic       [PARITY_WIDTH-1:0] parity;

  assign data_padded = PADDED_DATA_WIDTH'(data);

  // Parity straight from the data positions
  // Other parity positions never share a syndrome bit with this one,
  // so leaving them out keeps the logic free of feedback through the block
  always_comb begin
    int data_index;
    parity     = '0;
    data_index = 0;
    for (int position = 1; position <= PADDED_BLOCK_WIDTH; position++) begin
      if (!is_parity_position(position)) begin
        for (int parity_index = 0; parity_index < PARITY_WIDTH; parity_index++) begin
          // Bit belongs to the group of this parity bit
          if (covers_position(position, parity_index)) begin
            parity[parity_index] = parity[parity_index] ^ data_padded[data_index];
          end
        end
        data_index++;
      end
    end
  end

  // Place data and parity at their block positions
  hamming_block_packer #(
    .DATA_WIDTH ( PADDED_DATA_WIDTH )
  ) packer (
    .data  ( data_padded  ),
    .code  ( parity       ),
    .block ( block_padded )
  );

  assign code = parity;

  // Padding lives at the top of the block, drop it
  assign block = block_padded[BLOCK_WIDTH-1:0];

endmodule

//--- hamming/hamming_syndrome.sv
`timescale 1ns/100ps

`include "hamming.svh"

module hamming_syndrome import hamming_pkg::*; #(
  parameter  DATA_WIDTH   = 8,
  localparam PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH,
  // Block with its syndrome, handed to the corrector
  localparam type syndrome_stage_t = struct packed {
    logic [BLOCK_WIDTH-1:0] block;
    syndrome_t              syndrome;
  }
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [BLOCK_WIDTH-1:0] block,
  input  logic                   block_valid,
  output syndrome_stage_t        stage,
  output logic                   stage_valid
);

  logic [PARITY_WIDTH-1:0] syndrome;

  // Each syndrome bit re-checks one parity group
  // The parity bit is included here, so a clean block gives all zeros
  // and a single flip gives the position of the flipped bit
  always_comb begin
    syndrome = '0;
    for (int position = 1; position <= BLOCK_WIDTH; position++) begin
      for (int syndrome_bit = 0; syndrome_bit < PARITY_WIDTH; syndrome_bit++) begin
        if (covers_position(position, syndrome_bit)) begin
          syndrome[syndrome_bit] = syndrome[syndrome_bit] ^ block[position-1];
        end
      end
    end
  end

  // Payload only moves on an accepted word
  always_ff @(posedge clock) begin
    if (block_valid) begin
      stage.block    <= block;
      stage.syndrome <= syndrome_t'(syndrome);
    end
  end

  // One word per valid cycle, no stall
  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= block_valid;
    end
  end

  // Downstream qualifies everything on this strobe
  assert property (@(posedge clock) disable iff (reset) !$isunknown(stage_valid))
    else $error("stage_valid is unknown after reset");

endmodule

//--- hamming/hamming_corrector.sv
`timescale 1ns/100ps

`include "hamming.svh"

module hamming_corrector import hamming_pkg::*; #(
  parameter  DATA_WIDTH   = 8,
  localparam PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH,
  // Must match the stage layout of the syndrome module
  localparam type syndrome_stage_t = struct packed {
    logic [BLOCK_WIDTH-1:0] block;
    syndrome_t              syndrome;
  }
) (
  input  logic                  clock,
  input  logic                  reset,
  input  syndrome_stage_t       stage,
  input  logic                  stage_valid,
  output logic [DATA_WIDTH-1:0] data,
  output decode_status_t        status,
  output logic                  data_valid
);

  logic [BLOCK_WIDTH-1:0] flip_mask;
  logic [BLOCK_WIDTH-1:0] corrected_block;
  logic  [DATA_WIDTH-1:0] unpacked_data;
  decode_status_t         next_status;

  // One-hot mask of the position named by the syndrome
  // Stays empty for zero and for positions past a shortened block
  always_comb begin
    flip_mask = '0;
    for (int position = 1; position <= BLOCK_WIDTH; position++) begin
      flip_mask[position-1] = (stage.syndrome == syndrome_t'(position));
    end
  end

  assign corrected_block = stage.block ^ flip_mask;

  // Out of range syndrome leaves the block as it is and is flagged
  always_comb begin
    next_status.syndrome  = stage.syndrome;
    next_status.error     = (stage.syndrome != '0);
    next_status.corrected = |flip_mask;
    // Invalid straight from the range of the syndrome
    next_status.invalid   = (stage.syndrome > syndrome_t'(BLOCK_WIDTH));
  end

  // Parity bits are not needed past this point
  hamming_block_unpacker #(
    .DATA_WIDTH ( DATA_WIDTH )
  ) unpacker (
    .block ( corrected_block ),
    .data  ( unpacked_data   ),
    .code  (                 )
  );

  // Result registers, qualified by data_valid
  always_ff @(posedge clock) begin
    if (stage_valid) begin
      data   <= unpacked_data;
      status <= next_status;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      data_valid <= 1'b0;
    end else begin
      data_valid <= stage_valid;
    end
  end

  // Status flags are exclusive, and any flag implies an error
  assert property (@(posedge clock) disable iff (reset)
    data_valid |-> !(status.corrected && status.invalid))
    else $error("corrected and invalid both set");

  assert property (@(posedge clock) disable iff (reset)
    data_valid && (status.corrected || status.invalid) |-> status.error)
    else $error("status flag set without error");

endmodule

//--- source/hamming_codec.sv
`timescale 1ns/100ps

`include "hamming.svh"

module hamming_codec import hamming_pkg::*; #(
  parameter  DATA_WIDTH   = 8,
  localparam PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH,
  localparam type syndrome_stage_t = struct packed {
    logic [BLOCK_WIDTH-1:0] block;
    syndrome_t              syndrome;
  }
) (
  input  logic                    clock,
  input  logic                    reset,
  // Encode path, combinational
  input  logic   [DATA_WIDTH-1:0] data,
  output logic [PARITY_WIDTH-1:0] code,
  output logic  [BLOCK_WIDTH-1:0] block,
  // Decode path, results two edges after block_valid
  input  logic  [BLOCK_WIDTH-1:0] block_in,
  input  logic                    block_valid,
  output logic   [DATA_WIDTH-1:0] data_out,
  output decode_status_t          status,
  output logic                    data_valid
);

  syndrome_stage_t stage;
  logic            stage_valid;

  hamming_encoder #(
    .DATA_WIDTH ( DATA_WIDTH )
  ) encoder (
    .data  ( data  ),
    .code  ( code  ),
    .block ( block )
  );

  // Stage one, syndrome
  hamming_syndrome #(
    .DATA_WIDTH ( DATA_WIDTH )
  ) syndrome_stage (
    .clock       ( clock       ),
    .reset       ( reset       ),
    .block       ( block_in    ),
    .block_valid ( block_valid ),
    .stage       ( stage       ),
    .stage_valid ( stage_valid )
  );

  // Stage two, correction and unpack
  hamming_corrector #(
    .DATA_WIDTH ( DATA_WIDTH )
  ) corrector (
    .clock       ( clock       ),
    .reset       ( reset       ),
    .stage       ( stage       ),
    .stage_valid ( stage_valid ),
    .data        ( data_out    ),
    .status      ( status      ),
    .data_valid  ( data_valid  )
  );

endmodule

//--- test/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
  parameter CLOCK_PERIOD = 100,
  parameter RESET_CYCLES = 5
) (
  output logic clock,
  output logic reset
);

  // Free running clock, first rising edge half a period in
  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  // Reset held over the first rising edges, dropped on a falling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

//--- test/hamming_codec_tb.sv
`timescale 1ns/100ps

module hamming_codec_tb import hamming_pkg::*;;

  // Full length code, 11 data bits, 4 parity bits, 15 bit block
  localparam int DATA_WIDTH   = 11;
  localparam int PARITY_WIDTH = 4;
  localparam int BLOCK_WIDTH  = 15;

  localparam int CLOCK_PERIOD = 100;
  localparam int RESET_CYCLES = 5;
  localparam int IDLE_CYCLES  = 3;
  localparam int NUM_CYCLES   = 600;
  localparam int DRAIN_LIMIT  = 4;
  // Whole run in cycles plus some slack
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CYCLES + 2 * DRAIN_LIMIT + 20;
  localparam logic [31:0] SEED = 32'hf0a4_c42a;

  logic                    clock;
  logic                    reset;
  logic   [DATA_WIDTH-1:0] data;
  logic [PARITY_WIDTH-1:0] code;
  logic  [BLOCK_WIDTH-1:0] block;
  logic  [BLOCK_WIDTH-1:0] block_in;
  logic                    block_valid;
  logic   [DATA_WIDTH-1:0] data_out;
  decode_status_t          status;
  logic                    data_valid;

  // Expected encoder outputs for the word on data
  logic [PARITY_WIDTH-1:0] expected_code;
  logic  [BLOCK_WIDTH-1:0] expected_block;

  // Results still in flight, oldest first
  logic [DATA_WIDTH-1:0] expected_data_q[$];
  decode_status_t        expected_status_q[$];

  // Accepted strobes of the last two edges
  logic [1:0] accepted_pipe;
  int         result_count;
  int         sent_count;

  clock_gen #(
    .CLOCK_PERIOD ( CLOCK_PERIOD ),
    .RESET_CYCLES ( RESET_CYCLES )
  ) clock_source (
    .clock ( clock ),
    .reset ( reset )
  );

  hamming_codec #(
    .DATA_WIDTH ( DATA_WIDTH )
  ) UUT (
    .clock       ( clock       ),
    .reset       ( reset       ),
    .data        ( data        ),
    .code        ( code        ),
    .block       ( block       ),
    .block_in    ( block_in    ),
    .block_valid ( block_valid ),
    .data_out    ( data_out    ),
    .status      ( status      ),
    .data_valid  ( data_valid  )
  );

  // Data bits go to every position that is not a power of two,
  // then each parity bit makes its group even
  function automatic logic [BLOCK_WIDTH-1:0] encode_word(input logic [DATA_WIDTH-1:0] word);
    logic  [BLOCK_WIDTH-1:0] result;
    logic [PARITY_WIDTH-1:0] parity;
    int                      next_bit;
    result   = '0;
    parity   = '0;
    next_bit = 0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        result[pos-1] = word[next_bit];
        next_bit++;
      end
    end
    for (int bit_index = 0; bit_index < PARITY_WIDTH; bit_index++) begin
      for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
        if (pos[bit_index]) parity[bit_index] = parity[bit_index] ^ result[pos-1];
      end
    end
    // Parity positions 1, 2, 4, 8
    result[0] = parity[0];
    result[1] = parity[1];
    result[3] = parity[2];
    result[7] = parity[3];
    return result;
  endfunction

  function automatic logic [PARITY_WIDTH-1:0] parity_code(input logic [BLOCK_WIDTH-1:0] blk);
    return {blk[7], blk[3], blk[1], blk[0]};
  endfunction

  // Payload bits back out of a block, lowest position first
  function automatic logic [DATA_WIDTH-1:0] extract_data(input logic [BLOCK_WIDTH-1:0] blk);
    logic [DATA_WIDTH-1:0] word;
    int                    next_bit;
    word     = '0;
    next_bit = 0;
    for (int pos = 1; pos <= BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        word[next_bit] = blk[pos-1];
        next_bit++;
      end
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1, "Stopping on the first mismatch");
    end
  endtask

  // Mirrors the two register stages of the decoder
  always @(posedge clock) begin
    if (reset) begin
      accepted_pipe <= 2'b00;
    end else begin
      accepted_pipe <= {accepted_pipe[0], block_valid};
    end
  end

  // Called on a falling edge, before the next inputs go out
  task automatic sample_outputs();
    logic [DATA_WIDTH-1:0] exp_data;
    decode_status_t        exp_status;
    check_value("encode code", 64'(expected_code), 64'(code));
    check_value("encode block", 64'(expected_block), 64'(block));
    check_value("data_valid timing", 64'(accepted_pipe[1]), 64'(data_valid));
    if (data_valid) begin
      if (expected_data_q.size() == 0) begin
        $display("Test FAILED");
        $fatal(1, "data_valid is high but no block is outstanding");
      end else begin
        exp_data   = expected_data_q.pop_front();
        exp_status = expected_status_q.pop_front();
        check_value($sformatf("decode data, result %0d", result_count),
                    64'(exp_data), 64'(data_out));
        check_value($sformatf("decode status, result %0d", result_count),
                    64'(exp_status), 64'(status));
        result_count++;
      end
    end
  endtask

  // One cycle of stimulus, a word for the encoder and maybe a block for the decoder
  task automatic drive_inputs(input int cycle_index, input logic allow_valid);
    logic   [DATA_WIDTH-1:0] word;
    logic  [BLOCK_WIDTH-1:0] clean;
    logic  [BLOCK_WIDTH-1:0] corrupt;
    logic   [DATA_WIDTH-1:0] exp_data;
    decode_status_t          exp_status;
    logic                    send;
    int                      gap_roll;
    int                      flips;
    int                      first_pos;
    int                      second_pos;
    int                      syndrome;
    word       = DATA_WIDTH'($urandom());
    gap_roll   = $urandom_range(0, 3);
    flips      = $urandom_range(0, 2);
    first_pos  = $urandom_range(1, BLOCK_WIDTH);
    second_pos = $urandom_range(1, BLOCK_WIDTH - 1);
    // Second flip always lands somewhere else
    if (second_pos >= first_pos) second_pos++;
    // Corner words go first and are always sent
    if (cycle_index == IDLE_CYCLES) word = '0;
    if (cycle_index == IDLE_CYCLES + 1) word = '1;
    send = allow_valid && (cycle_index >= IDLE_CYCLES) &&
           ((cycle_index < IDLE_CYCLES + 2) || (gap_roll != 0));
    clean      = encode_word(word);
    corrupt    = clean;
    exp_data   = word;
    exp_status = '0;
    syndrome   = 0;
    if (flips >= 1) begin
      corrupt[first_pos-1] = ~corrupt[first_pos-1];
      syndrome             = first_pos;
    end
    if (flips == 2) begin
      corrupt[second_pos-1] = ~corrupt[second_pos-1];
      syndrome              = first_pos ^ second_pos;
      // Miscorrection, the decoder flips a third bit
      exp_data = extract_data(corrupt ^ (BLOCK_WIDTH'(1) << (syndrome - 1)));
    end
    if (syndrome != 0) begin
      exp_status.error     = 1'b1;
      exp_status.corrected = 1'b1;
      exp_status.syndrome  = syndrome_t'(syndrome);
    end
    data           = word;
    expected_block = clean;
    expected_code  = parity_code(clean);
    block_valid    = send;
    // Junk on the block bus while idle
    if (send) begin
      block_in = corrupt;
      expected_data_q.push_back(exp_data);
      expected_status_q.push_back(exp_status);
      sent_count++;
    end else begin
      block_in = BLOCK_WIDTH'($urandom());
    end
  endtask

  initial begin
    void'($urandom(SEED));
    data           = '0;
    block_in       = '0;
    block_valid    = 1'b0;
    expected_block = encode_word('0);
    expected_code  = parity_code(expected_block);
    result_count   = 0;
    sent_count     = 0;
    @(negedge reset);
    // Idle cycles first, then random gaps in the stream
    for (int cycle_index = 0; cycle_index < NUM_CYCLES; cycle_index++) begin
      @(negedge clock);
      sample_outputs();
      drive_inputs(cycle_index, 1'b1);
    end
    // Let the pipeline empty
    repeat (DRAIN_LIMIT) begin
      @(negedge clock);
      sample_outputs();
      drive_inputs(NUM_CYCLES, 1'b0);
    end
    // No stray results after the last one
    repeat (DRAIN_LIMIT) begin
      @(negedge clock);
      sample_outputs();
      drive_inputs(NUM_CYCLES, 1'b0);
    end
    $display("Blocks sent %0d, results checked %0d", sent_count, result_count);
    if (expected_data_q.size() != 0 || result_count != sent_count) begin
      $display("Test FAILED");
      $fatal(1, "Some blocks never produced a result");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Test FAILED");
    $fatal(1, "Timeout, the run did not finish in time");
  end

endmodule

//--- hamming_codec.f
+incdir+common
common/hamming_pkg.sv
hamming/hamming_block_packer.sv
hamming/hamming_block_unpacker.sv
hamming/hamming_encoder.sv
hamming/hamming_syndrome.sv
hamming/hamming_corrector.sv
source/hamming_codec.sv
test/clock_gen.sv
test/hamming_codec_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module hamming_codec_tb \
		-f hamming_codec.f -o hamming_codec_sim
	./obj_dir/hamming_codec_sim

clean:
	rm -rf obj_dir
